//--- hw/fir_pkg.sv
`default_nettype none

package fir_pkg;

    // filter geometry
    localparam int NUM_TAPS = 11;           // coefficients and history depth
    localparam int ADDR_W   = 12;           // register port address bits
    localparam int DATA_W   = 32;           // samples, coefficients and y

    // widths that carry a meaning
    typedef logic [ADDR_W-1:0]           addr_t;
    typedef logic [DATA_W-1:0]           data_t;
    typedef logic [$clog2(NUM_TAPS)-1:0] tap_idx_t;   // 0 to 10
    typedef logic [DATA_W-1:0]           len_t;       // samples per run

    // register map
    localparam addr_t REG_CTRL = 12'h000;   // ap control and status
    localparam addr_t REG_LEN  = 12'h010;   // data length
    localparam addr_t TAP_BASE = 12'h040;   // coef i at TAP_BASE + 4*i

    // control states
    typedef enum logic [1:0] {
        AP_IDLE,
        AP_RUN,
        AP_DONE
    } ap_state_e;

    // one tap request from the issue stage
    typedef struct packed {
        tap_idx_t tap;
        logic     first;          // tap 0, acc reloads
        logic     last;           // tap 10, sum complete
        logic     stream_last;    // final sample of the run
    } issue_req_t;

    // history read for x[n-i]
    typedef struct packed {
        data_t x;
        logic  first;
        logic  last;
        logic  stream_last;
    } fetch_t;

    // h[i] * x[n-i], wrapped to 32 bits
    typedef struct packed {
        data_t p;
        logic  first;
        logic  last;
        logic  stream_last;
    } prod_t;

endpackage

`default_nettype wire

//--- hw/fir_cfg_regs.sv
`default_nettype none

module fir_cfg_regs (
    input  logic              axis_clk,
    input  logic              axis_rst_n,
    // write channel
    input  logic              awvalid,
    input  logic              wvalid,
    input  fir_pkg::addr_t    awaddr,
    input  fir_pkg::data_t    wdata,
    output logic              awready,
    output logic              wready,
    // read channel
    input  logic              arvalid,
    input  logic              rready,
    input  fir_pkg::addr_t    araddr,
    output logic              arready,
    output logic              rvalid,
    output fir_pkg::data_t    rdata,
    // datapath side
    input  fir_pkg::tap_idx_t coef_idx,
    input  logic              stream_done,
    input  logic              ss_tready,
    input  logic              sm_tvalid,
    output logic              run_start,
    output logic              running,
    output fir_pkg::len_t     data_length,
    output fir_pkg::data_t    coef
);

    import fir_pkg::*;

    ap_state_e state;
    data_t     coefs [NUM_TAPS];    // h[0..10]
    logic      wr_en;
    logic      cfg_wr;              // config writes only land while idle
    logic      rd_ctrl;
    logic      idle;
    logic      done;
    data_t     rd_mux;

    // word aligned and inside the coefficient window
    function automatic logic is_tap(input addr_t a);
        return (a >= TAP_BASE) && (a < TAP_BASE + addr_t'(4 * NUM_TAPS)) &&
               (a[1:0] == 2'b00);
    endfunction

    function automatic tap_idx_t tap_of(input addr_t a);
        addr_t off;
        off = a - TAP_BASE;
        return tap_idx_t'(off >> 2);    // byte offset to tap index
    endfunction

    assign wr_en   = awvalid && wvalid;     // address and data together
    assign awready = wr_en;
    assign wready  = wr_en;
    assign arready = 1'b1;                  // reads never wait

    assign cfg_wr    = wr_en && (state == AP_IDLE);
    assign run_start = cfg_wr && (awaddr == REG_CTRL) && wdata[0];
    assign running   = (state == AP_RUN);
    assign rd_ctrl   = arvalid && (araddr == REG_CTRL);

    assign idle = (state != AP_RUN);        // stays up in done as well
    assign done = (state == AP_DONE);

    // ap control fsm
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state <= AP_IDLE;
        end else begin
            case (state)
                AP_IDLE: if (run_start)   state <= AP_RUN;
                AP_RUN:  if (stream_done) state <= AP_DONE;
                AP_DONE: if (rd_ctrl)     state <= AP_IDLE;    // status read clears done
                default: state <= AP_IDLE;
            endcase
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            data_length <= '0;
        end else if (cfg_wr && (awaddr == REG_LEN)) begin
            data_length <= wdata;
        end
    end

    // coefficient array
    always_ff @(posedge axis_clk) begin
        if (cfg_wr && is_tap(awaddr)) begin
            coefs[tap_of(awaddr)] <= wdata;
        end
    end

    // h[i] lookup, lines up with the history fetch
    always_ff @(posedge axis_clk) begin
        coef <= coefs[coef_idx];
    end

    // read decode, status bits built at read time
    always_comb begin
        rd_mux = '0;
        if (araddr == REG_CTRL) begin
            // bit 0 start reads back as zero, bit 3 reserved
            rd_mux = {{(DATA_W-6){1'b0}}, sm_tvalid, ss_tready, 1'b0, idle, done, 1'b0};
        end else if (araddr == REG_LEN) begin
            rd_mux = data_length;
        end else if (is_tap(araddr)) begin
            rd_mux = coefs[tap_of(araddr)];
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            rvalid <= 1'b0;
        end else if (arvalid) begin
            rvalid <= 1'b1;         // one cycle after the address
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (arvalid) begin
            rdata <= rd_mux;
        end
    end

endmodule

`default_nettype wire

//--- hw/fir_issue.sv
`default_nettype none

module fir_issue (
    input  logic                axis_clk,
    input  logic                axis_rst_n,
    input  logic                run_start,
    input  logic                running,
    input  fir_pkg::len_t       data_length,
    input  logic                ss_tvalid,
    input  logic                stall,
    output logic                ss_tready,
    output fir_pkg::issue_req_t req,
    output logic                req_valid,
    output logic                accept
);

    import fir_pkg::*;

    len_t smp_cnt;      // samples taken this run
    logic step;         // move to the next tap

    // one sample at a time, never past the length
    assign ss_tready = running && !req_valid && (smp_cnt < data_length) && !stall;
    assign accept    = ss_tvalid && ss_tready;
    assign step      = req_valid && !stall;   // held request waits out the stall

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            smp_cnt   <= '0;
            req_valid <= 1'b0;
        end else if (run_start) begin
            smp_cnt   <= '0;
            req_valid <= 1'b0;
        end else if (accept) begin
            smp_cnt   <= smp_cnt + len_t'(1);
            req_valid <= 1'b1;              // tap 0 goes out right away
        end else if (step && req.last) begin
            req_valid <= 1'b0;              // tap 10 taken, reopen ss
        end
    end

    // tap sequencer
    always_ff @(posedge axis_clk) begin
        if (accept) begin
            req.tap         <= '0;
            req.first       <= 1'b1;
            req.last        <= 1'b0;
            // flag the final sample of the run
            req.stream_last <= (smp_cnt + len_t'(1)) == data_length;
        end else if (step && !req.last) begin
            req.tap   <= req.tap + tap_idx_t'(1);
            req.first <= 1'b0;
            req.last  <= (req.tap == tap_idx_t'(NUM_TAPS - 2));   // next one is tap 10
        end
    end

endmodule

`default_nettype wire

//--- hw/fir_sample_buf.sv
`default_nettype none

module fir_sample_buf (
    input  logic                axis_clk,
    input  logic                axis_rst_n,
    input  logic                run_start,
    input  logic                accept,
    input  fir_pkg::data_t      ss_tdata,
    input  fir_pkg::issue_req_t req,
    input  logic                req_valid,
    input  logic                stall,
    output fir_pkg::fetch_t     fetch,
    output logic                fetch_valid
);

    import fir_pkg::*;

    data_t      hist [NUM_TAPS];    // circular x history
    tap_idx_t   ptr;                // slot of x[n]
    tap_idx_t   next_ptr;
    tap_idx_t   rd_pos;             // slot of x[n-i]
    logic [4:0] wrap_pos;           // one bit wider for ptr + 11

    assign next_ptr = (ptr == tap_idx_t'(NUM_TAPS - 1)) ? '0 : ptr + tap_idx_t'(1);

    // ptr - i modulo 11
    assign wrap_pos = {1'b0, ptr} + 5'(NUM_TAPS) - {1'b0, req.tap};
    assign rd_pos   = (ptr >= req.tap) ? ptr - req.tap : tap_idx_t'(wrap_pos);

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            ptr <= '0;
        end else if (run_start) begin
            ptr <= '0;
        end else if (accept) begin
            ptr <= next_ptr;
        end
    end

    // newest sample lands on the accepting edge, read by tap 0 next cycle
    always_ff @(posedge axis_clk) begin
        if (run_start) begin
            for (int i = 0; i < NUM_TAPS; i++) begin
                hist[i] <= '0;      // x before the run counts as zero
            end
        end else if (accept) begin
            hist[next_ptr] <= ss_tdata;
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= req_valid && !stall;    // a held request fetches once
        end
    end

    always_ff @(posedge axis_clk) begin
        fetch.x           <= hist[rd_pos];
        fetch.first       <= req.first;
        fetch.last        <= req.last;
        fetch.stream_last <= req.stream_last;
    end

endmodule

`default_nettype wire

//--- hw/fir_mac.sv
`default_nettype none

module fir_mac (
    input  logic            axis_clk,
    input  logic            axis_rst_n,
    input  fir_pkg::fetch_t fetch,
    input  logic            fetch_valid,
    input  fir_pkg::data_t  coef,
    input  logic            sm_tready,
    output logic            stall,
    output logic            stream_done,
    output logic            sm_tvalid,
    output fir_pkg::data_t  sm_tdata,
    output logic            sm_tlast
);

    import fir_pkg::*;

    prod_t prod;
    logic  prod_valid;
    data_t acc;             // running sum
    logic  acc_done;        // acc holds a finished y
    logic  acc_tlast;

    // y stuck in the output register
    assign stall       = sm_tvalid && !sm_tready;
    assign stream_done = sm_tvalid && sm_tready && sm_tlast;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            prod_valid <= 1'b0;
            acc_done   <= 1'b0;
            sm_tvalid  <= 1'b0;
            sm_tlast   <= 1'b0;
        end else begin
            prod_valid <= fetch_valid;
            acc_done   <= prod_valid && prod.last;
            if (acc_done) begin
                // issue gating keeps the output empty by the time a sum finishes
                sm_tvalid <= 1'b1;
                sm_tlast  <= acc_tlast;
            end else if (sm_tready) begin
                sm_tvalid <= 1'b0;
                sm_tlast  <= 1'b0;
            end
        end
    end

    // multiply stage, product wraps to 32 bits
    always_ff @(posedge axis_clk) begin
        prod.p           <= fetch.x * coef;
        prod.first       <= fetch.first;
        prod.last        <= fetch.last;
        prod.stream_last <= fetch.stream_last;
    end

    // accumulate stage
    always_ff @(posedge axis_clk) begin
        if (prod_valid) begin
            acc       <= prod.first ? prod.p : acc + prod.p;   // mod 2^32
            acc_tlast <= prod.stream_last;
        end
    end

    // output register, stable until sm_tready
    always_ff @(posedge axis_clk) begin
        if (acc_done) begin
            sm_tdata <= acc;
        end
    end

endmodule

`default_nettype wire

//--- hw/fir_top.sv
`default_nettype none

module fir_top (
    input  logic           axis_clk,
    input  logic           axis_rst_n,
    // register port
    input  logic           awvalid,
    input  logic           wvalid,
    input  fir_pkg::addr_t awaddr,
    input  fir_pkg::data_t wdata,
    output logic           awready,
    output logic           wready,
    input  logic           arvalid,
    input  logic           rready,
    input  fir_pkg::addr_t araddr,
    output logic           arready,
    output logic           rvalid,
    output fir_pkg::data_t rdata,
    // x stream in
    input  logic           ss_tvalid,
    input  fir_pkg::data_t ss_tdata,
    output logic           ss_tready,
    // y stream out
    input  logic           sm_tready,
    output logic           sm_tvalid,
    output fir_pkg::data_t sm_tdata,
    output logic           sm_tlast
);

    import fir_pkg::*;

    logic       run_start;
    logic       running;
    len_t       data_length;
    data_t      coef;           // h[i] for the tap in fetch
    issue_req_t req;
    logic       req_valid;
    logic       accept;
    fetch_t     fetch;
    logic       fetch_valid;
    logic       stall;
    logic       stream_done;

    fir_cfg_regs i_cfg_regs (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .awvalid     (awvalid),
        .wvalid      (wvalid),
        .awaddr      (awaddr),
        .wdata       (wdata),
        .awready     (awready),
        .wready      (wready),
        .arvalid     (arvalid),
        .rready      (rready),
        .araddr      (araddr),
        .arready     (arready),
        .rvalid      (rvalid),
        .rdata       (rdata),
        .coef_idx    (req.tap),
        .stream_done (stream_done),
        .ss_tready   (ss_tready),
        .sm_tvalid   (sm_tvalid),
        .run_start   (run_start),
        .running     (running),
        .data_length (data_length),
        .coef        (coef)
    );

    fir_issue i_issue (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .run_start   (run_start),
        .running     (running),
        .data_length (data_length),
        .ss_tvalid   (ss_tvalid),
        .stall       (stall),
        .ss_tready   (ss_tready),
        .req         (req),
        .req_valid   (req_valid),
        .accept      (accept)
    );

    fir_sample_buf i_sample_buf (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .run_start   (run_start),
        .accept      (accept),
        .ss_tdata    (ss_tdata),
        .req         (req),
        .req_valid   (req_valid),
        .stall       (stall),
        .fetch       (fetch),
        .fetch_valid (fetch_valid)
    );

    fir_mac i_mac (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .fetch       (fetch),
        .fetch_valid (fetch_valid),
        .coef        (coef),
        .sm_tready   (sm_tready),
        .stall       (stall),
        .stream_done (stream_done),
        .sm_tvalid   (sm_tvalid),
        .sm_tdata    (sm_tdata),
        .sm_tlast    (sm_tlast)
    );

endmodule

`default_nettype wire

//--- bench/fir_tb_assert.sv
`default_nettype none

module fir_tb_assert (
    input logic           axis_clk,
    input logic           axis_rst_n,
    input logic           awready,
    input logic           wready,
    input logic           arvalid,
    input logic           rvalid,
    input logic           ss_tready,
    input logic           sm_tvalid,
    input logic           sm_tready,
    input logic           sm_tlast,
    input fir_pkg::data_t sm_tdata
);

    int unsigned assert_fails = 0;      // failed property count

    // y frozen while the sink pushes back
    hold_y: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        (sm_tvalid && !sm_tready) |=> ($stable(sm_tdata) && $stable(sm_tlast)))
    else begin
        assert_fails++;
        $error("sm_tdata or sm_tlast moved while sm_tvalid waited for sm_tready");
    end

    // tlast only rides on a valid beat
    tlast_valid: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        sm_tlast |-> sm_tvalid)
    else begin
        assert_fails++;
        $error("sm_tlast high without sm_tvalid");
    end

    rvalid_follows: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        arvalid |=> rvalid)     // read data one cycle after the address
    else begin
        assert_fails++;
        $error("rvalid did not rise one cycle after arvalid");
    end

    // sampled mid cycle, after the first edge has applied reset
    reset_quiet: assert property (@(negedge axis_clk)
        !axis_rst_n |-> (!awready && !wready && !rvalid && !ss_tready &&
                         !sm_tvalid && !sm_tlast))
    else begin
        assert_fails++;
        $error("control outputs not low during reset");
    end

endmodule

`default_nettype wire

//--- bench/fir_tb.sv
`default_nettype none

module fir_tb;

    import fir_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int RST_CYCLES  = 8;
    localparam int LEN_A       = 20;    // sink always ready
    localparam int LEN_B       = 15;    // random sink gaps
    localparam int WDOG_CYCLES = (LEN_A + LEN_B) * 40 + 2000;

    logic  axis_clk;
    logic  axis_rst_n;
    logic  awvalid;
    logic  wvalid;
    addr_t awaddr;
    data_t wdata;
    logic  awready;
    logic  wready;
    logic  arvalid;
    logic  rready;
    addr_t araddr;
    logic  arready;
    logic  rvalid;
    data_t rdata;
    logic  ss_tvalid;
    data_t ss_tdata;
    logic  ss_tready;
    logic  sm_tready;
    logic  sm_tvalid;
    data_t sm_tdata;
    logic  sm_tlast;

    data_t       hc [NUM_TAPS];         // model coefficients
    data_t       xs [$];                // x samples of the current run
    logic [31:0] lcg_state;
    int          errors;
    int          cur_len;               // samples in the current run
    int          ss_taken;              // accepted so far, counted by the gate monitor
    int          gate_errors = 0;

    fir_top i_fir_top (.*);

    bind fir_top fir_tb_assert i_fir_tb_assert (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awready    (awready),
        .wready     (wready),
        .arvalid    (arvalid),
        .rvalid     (rvalid),
        .ss_tready  (ss_tready),
        .sm_tvalid  (sm_tvalid),
        .sm_tready  (sm_tready),
        .sm_tlast   (sm_tlast),
        .sm_tdata   (sm_tdata)
    );

    initial begin
        axis_clk = 1'b0;
        forever #(CLK_PERIOD / 2) axis_clk = ~axis_clk;
    end

    // run length bound
    initial begin
        #(WDOG_CYCLES * CLK_PERIOD);
        $display("Error at %0t: watchdog expired before the runs finished", $time);
        $display("TEST FAILED");
        $finish;
    end

    function automatic data_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // y[n] = sum h[i] * x[n-i], x zero before the run, all mod 2^32
    function automatic data_t expected_y(input int n);
        data_t acc;
        acc = '0;
        for (int i = 0; i < NUM_TAPS; i++) begin
            if (n - i >= 0) begin
                acc = acc + hc[i] * xs[n - i];
            end
        end
        return acc;
    endfunction

    // control word as the register map lays it out, start and bit 3 read zero
    function automatic data_t ctrl_word(input bit done, input bit idle, input bit ss_rdy,
                                        input bit sm_vld);
        data_t w;
        w    = '0;
        w[1] = done;
        w[2] = idle;
        w[4] = ss_rdy;
        w[5] = sm_vld;
        return w;
    endfunction

    task automatic check_value(input string name, input data_t got, input data_t exp);
        assert (got === exp) else begin
            errors++;
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            errors++;
            $display("Fail at %0t: %s got %0b expected %0b", $time, name, got, exp);
        end
    endtask

    task automatic write_reg(input addr_t addr, input data_t data);
        @(posedge axis_clk);
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        awaddr  <= addr;
        wdata   <= data;
        do begin
            @(negedge axis_clk);
        end while (!(awready && wready));   // both channels go together
        @(posedge axis_clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
    endtask

    task automatic read_reg(input addr_t addr, output data_t data);
        @(posedge axis_clk);
        arvalid <= 1'b1;
        araddr  <= addr;
        do begin
            @(negedge axis_clk);
        end while (!arready);
        @(posedge axis_clk);
        arvalid <= 1'b0;                    // single address beat
        do begin
            @(negedge axis_clk);
        end while (!rvalid);
        data = rdata;
    endtask

    task automatic drive_samples(input int len);
        int n;
        n = 0;
        while (n < len) begin
            @(posedge axis_clk);
            ss_tvalid <= 1'b1;
            ss_tdata  <= xs[n];
            @(negedge axis_clk);
            if (ss_tready) begin
                n++;                        // taken on the coming edge
            end
        end
        // keep offering, ss_tready has to stay low now
        @(posedge axis_clk);
        ss_tdata <= ~xs[len - 1];
    endtask

    task automatic collect_outputs(input int len, input bit gaps);
        int n;
        n = 0;
        while (n < len) begin
            @(posedge axis_clk);
            sm_tready <= gaps ? (lcg_next() % 3 != 0) : 1'b1;  // ready two in three
            @(negedge axis_clk);
            if (sm_tvalid && sm_tready) begin
                check_value($sformatf("sm_tdata[%0d]", n), sm_tdata, expected_y(n));
                check_flag($sformatf("sm_tlast[%0d]", n), sm_tlast, n == len - 1);
                n++;
            end
        end
    endtask

    // no sample past the length
    always @(negedge axis_clk) begin
        if (axis_rst_n && ss_tready) begin
            assert (ss_taken < cur_len) else begin
                gate_errors++;
                $display("Error at %0t: ss_tready high after %0d of %0d samples were taken",
                         $time, ss_taken, cur_len);
            end
        end
        if (!ss_tvalid) begin
            ss_taken = 0;                   // source idle between runs
        end else if (ss_tready) begin
            ss_taken++;
        end
    end

    task automatic run_test(input int len, input bit gaps);
        data_t rd;
        addr_t tap3;
        tap3 = TAP_BASE + addr_t'(12);
        // new coefficients and length while idle
        for (int i = 0; i < NUM_TAPS; i++) begin
            hc[i] = lcg_next();
            write_reg(TAP_BASE + addr_t'(4 * i), hc[i]);
        end
        write_reg(REG_LEN, data_t'(len));
        for (int i = 0; i < NUM_TAPS; i++) begin
            read_reg(TAP_BASE + addr_t'(4 * i), rd);
            check_value($sformatf("rdata tap %0d", i), rd, hc[i]);
        end
        read_reg(REG_LEN, rd);
        check_value("rdata data_length", rd, data_t'(len));
        xs.delete();
        for (int n = 0; n < len; n++) begin
            xs.push_back(lcg_next());
        end
        cur_len = len;
        write_reg(REG_CTRL, 32'h1);         // ap_start
        read_reg(REG_CTRL, rd);
        // running with nothing issued yet, so ss_tready is up
        check_value("rdata status", rd, ctrl_word(1'b0, 1'b0, 1'b1, 1'b0));
        // tap write in AP_RUN is dropped
        write_reg(tap3, ~hc[3]);
        read_reg(tap3, rd);
        check_value("rdata tap 3", rd, hc[3]);
        fork
            drive_samples(len);
            collect_outputs(len, gaps);
        join
        read_reg(REG_CTRL, rd);
        check_value("rdata status", rd, ctrl_word(1'b1, 1'b1, 1'b0, 1'b0));
        read_reg(REG_CTRL, rd);             // done cleared by the first read
        check_value("rdata status", rd, ctrl_word(1'b0, 1'b1, 1'b0, 1'b0));
        @(posedge axis_clk);
        ss_tvalid <= 1'b0;
    endtask

    initial begin
        data_t rd;
        lcg_state  = 32'd44;
        errors     = 0;
        cur_len    = 0;
        axis_rst_n = 1'b0;
        awvalid    = 1'b0;
        wvalid     = 1'b0;
        awaddr     = '0;
        wdata      = '0;
        arvalid    = 1'b0;
        araddr     = '0;
        rready     = 1'b1;                  // reads drained at once
        ss_tvalid  = 1'b0;
        ss_tdata   = '0;
        sm_tready  = 1'b1;
        repeat (RST_CYCLES) @(posedge axis_clk);
        axis_rst_n <= 1'b1;

        read_reg(REG_CTRL, rd);             // status straight out of reset
        check_value("rdata status", rd, ctrl_word(1'b0, 1'b1, 1'b0, 1'b0));

        run_test(LEN_A, 1'b0);
        run_test(LEN_B, 1'b1);              // history must start from zero again
        repeat (4) @(posedge axis_clk);

        $display("Errors: %0d value checks, %0d ss gating, %0d assertions",
                 errors, gate_errors, i_fir_top.i_fir_tb_assert.assert_fails);
        if (errors == 0 && gate_errors == 0 &&
            i_fir_top.i_fir_tb_assert.assert_fails == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
hw/fir_pkg.sv
hw/fir_cfg_regs.sv
hw/fir_issue.sv
hw/fir_sample_buf.sv
hw/fir_mac.sv
hw/fir_top.sv
bench/fir_tb_assert.sv
bench/fir_tb.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the fir testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module fir_tb -f list.f -o fir_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

# a failing $error must not stop the run before the testbench summary
out=$(./obj_dir/fir_sim +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1
